// File: entry_ageing.f
+incdir+include
logic/ageing_pkg.sv
logic/ageing_timer.sv
logic/ageing_ctrl_regs.sv
logic/ageing_table.sv
logic/timer_expiry.sv
logic/entry_ageing.sv
bench/entry_ageing_properties.sv
bench/entry_ageing_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := entry_ageing_tb
FILELIST  := entry_ageing.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
PASS_TEXT := Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/entry_ageing_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module entry_ageing_tb;

    import ageing_pkg::*;

    // Run length, directed part is a generous upper bound
    localparam int RAND_CYCLES     = 4000;
    localparam int WRAP_CYCLES     = 67000;
    localparam int DIRECTED_CYCLES = 200;
    localparam int STIM_CYCLES     = RAND_CYCLES + WRAP_CYCLES + DIRECTED_CYCLES;
    localparam int CYCLE_LIMIT     = 2 * STIM_CYCLES + 100;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      tick;
    logic                      freeze;
    age_op_e                   op;
    logic [`AGE_IDX_WID-1:0]   idx;
    logic                      reg_wr;
    logic                      reg_rd;
    age_reg_e                  reg_addr;
    logic [`AGE_DATA_WID-1:0]  reg_wdata;
    logic [`AGE_DATA_WID-1:0]  reg_rdata;
    logic                      result_valid;
    logic [`AGE_IDX_WID-1:0]   result_idx;
    logic                      result_expired;

    // ------------------------------------------------
    // Reference model state
    // ------------------------------------------------
    logic                      m_enable;
    logic                      m_freeze;
    logic                      m_clear;
    logic [`AGE_TIMER_WID-1:0] m_timeout;
    logic [`AGE_TIMER_WID-1:0] m_timer;
    logic [`AGE_TIMER_WID-1:0] m_stamp [`AGE_ENTRIES];

    // Expected results, two edges deep
    logic                      p1_valid;
    logic [`AGE_IDX_WID-1:0]   p1_idx;
    logic                      p1_exp;
    logic                      p2_valid;
    logic [`AGE_IDX_WID-1:0]   p2_idx;
    logic                      p2_exp;

    // Pending register read
    logic                      rd_pend;
    logic [`AGE_DATA_WID-1:0]  rd_exp;

    logic [31:0] rng_state     = 32'h504c_aaae;
    int          cycle_count   = 0;
    int          result_errors = 0;
    int          reg_errors    = 0;
    int          other_errors  = 0;
    int          expired_hits  = 0;
    int          fresh_hits    = 0;
    int          boundary_hits = 0;
    int          wrap_hits     = 0;

    entry_ageing u_entry_ageing (
        .clk            (clk),
        .rst_n          (rst_n),
        .tick           (tick),
        .freeze         (freeze),
        .op             (op),
        .idx            (idx),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .result_valid   (result_valid),
        .result_idx     (result_idx),
        .result_expired (result_expired)
    );

    // 10 ns period
    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: test still running after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // LCG, upper half only since low bits cycle short
    function automatic logic [15:0] rand16();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    // Register contents as the map defines them
    function automatic logic [31:0] expected_read(age_reg_e addr);
        case (addr)
            AGE_REG_CONTROL: return {29'd0, m_clear, m_freeze, m_enable};
            AGE_REG_TIMEOUT: return {16'd0, m_timeout};
            AGE_REG_STATUS:  return {29'd0, ~m_clear, m_enable & ~m_clear, m_clear};
            default:         return {16'd0, m_timer};
        endcase
    endfunction

    // ------------------------------------------------
    // Model of one rising edge, inputs already driven
    // ------------------------------------------------
    task automatic model_edge();
        logic signed [`AGE_TIMER_WID-1:0] slack;
        p2_valid = p1_valid;
        p2_idx   = p1_idx;
        p2_exp   = p1_exp;
        p1_valid = 1'b0;
        if (op == AGE_OP_CHECK) begin
            // Idle time past the timeout, signed so wrap is harmless
            slack    = m_timer - m_stamp[idx] - m_timeout;
            p1_valid = 1'b1;
            p1_idx   = idx;
            p1_exp   = (slack >= 0);
            if (p1_exp)
                expired_hits++;
            else
                fresh_hits++;
            if (slack == 0)
                boundary_hits++;
            if (m_stamp[idx] > m_timer)
                wrap_hits++;
        end
        if (reg_rd) begin
            rd_pend = 1'b1;
            rd_exp  = expected_read(reg_addr);
        end
        if (op == AGE_OP_TOUCH)
            m_stamp[idx] = m_timer;
        // Clear beats counting
        if (m_clear)
            m_timer = '0;
        else if (tick && m_enable && !(freeze || m_freeze))
            m_timer = m_timer + 16'd1;
        if (reg_wr && reg_addr == AGE_REG_CONTROL) begin
            m_enable = reg_wdata[0];
            m_freeze = reg_wdata[1];
            m_clear  = reg_wdata[2];
        end else if (reg_wr && reg_addr == AGE_REG_TIMEOUT) begin
            m_timeout = reg_wdata[`AGE_TIMER_WID-1:0];
        end
    endtask

    task automatic compare_outputs();
        assert (result_valid === p2_valid) else begin
            result_errors++;
            $display("error: result_valid expected %h got %h", p2_valid, result_valid);
        end
        if (p2_valid) begin
            assert (result_idx === p2_idx) else begin
                result_errors++;
                $display("error: result_idx expected %h got %h", p2_idx, result_idx);
            end
            assert (result_expired === p2_exp) else begin
                result_errors++;
                $display("error: result_expired expected %h got %h (idx %h)",
                         p2_exp, result_expired, p2_idx);
            end
        end
        if (rd_pend) begin
            assert (reg_rdata === rd_exp) else begin
                reg_errors++;
                $display("error: reg_rdata expected %h got %h", rd_exp, reg_rdata);
            end
            rd_pend = 1'b0;
        end
    endtask

    // One clock, then back to idle inputs
    task automatic run_cycle();
        model_edge();
        @(negedge clk);
        compare_outputs();
        tick   = 1'b0;
        freeze = 1'b0;
        op     = AGE_OP_NONE;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
    endtask

    task automatic reg_write(age_reg_e addr, logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        run_cycle();
    endtask

    task automatic reg_read(age_reg_e addr);
        reg_rd   = 1'b1;
        reg_addr = addr;
        run_cycle();
    endtask

    // ------------------------------------------------
    // Random traffic
    // ------------------------------------------------
    task automatic random_cycle();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        a = rand16();
        b = rand16();
        c = rand16();
        tick   = a[15];
        freeze = (a[14:10] == 5'd0);
        case (a[9:7])
            3'd0, 3'd1, 3'd2: op = AGE_OP_TOUCH;
            3'd3, 3'd4, 3'd5: op = AGE_OP_CHECK;
            default:          op = AGE_OP_NONE;
        endcase
        idx = a[6:3];
        if (b[15:11] == 5'd0) begin
            reg_wr = 1'b1;
            if (b[10]) begin
                // Small timeout keeps both outcomes common
                reg_addr  = AGE_REG_TIMEOUT;
                reg_wdata = {28'd0, b[9:6]};
            end else begin
                reg_addr  = AGE_REG_CONTROL;
                reg_wdata = {29'd0, (b[5:3] == 3'd0), (b[2:1] == 2'd0), (b[0] | b[9])};
            end
        end else if (c[15:12] == 4'd0) begin
            reg_rd   = 1'b1;
            reg_addr = age_reg_e'(c[1:0]);
        end
        run_cycle();
    endtask

    // Ticking every cycle, sparse ops, long enough for the timer to wrap
    task automatic wrap_cycle();
        logic [15:0] a;
        a    = rand16();
        tick = 1'b1;
        idx  = a[3:0];
        if (a[8:4] == 5'd0)
            op = AGE_OP_TOUCH;
        else if (a[8:4] == 5'd1)
            op = AGE_OP_CHECK;
        run_cycle();
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        logic [15:0] r;
        rst_n     = 1'b0;
        tick      = 1'b0;
        freeze    = 1'b0;
        op        = AGE_OP_NONE;
        idx       = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = AGE_REG_CONTROL;
        reg_wdata = '0;
        m_enable  = 1'b0;
        m_freeze  = 1'b0;
        m_clear   = 1'b0;
        m_timeout = '0;
        m_timer   = '0;
        for (int i = 0; i < `AGE_ENTRIES; i++)
            m_stamp[i] = '0;
        p1_valid  = 1'b0;
        p2_valid  = 1'b0;
        rd_pend   = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (result_valid === 1'b0) else begin
            result_errors++;
            $display("error: result_valid expected 0 got %h after reset", result_valid);
        end

        // Disabled engine ignores ticks
        reg_read(AGE_REG_STATUS);
        repeat (20) begin
            tick = 1'b1;
            run_cycle();
        end
        reg_read(AGE_REG_TIMER);

        // Read-only registers ignore writes
        reg_write(AGE_REG_TIMEOUT, 32'h0000_0005);
        reg_read(AGE_REG_TIMEOUT);
        reg_write(AGE_REG_STATUS, 32'hffff_ffff);
        reg_write(AGE_REG_TIMER, 32'h0000_abcd);
        reg_read(AGE_REG_STATUS);
        reg_read(AGE_REG_TIMER);

        // Freeze bit, then the freeze pin
        reg_write(AGE_REG_CONTROL, 32'h0000_0003);
        reg_read(AGE_REG_CONTROL);
        repeat (10) begin
            tick = 1'b1;
            run_cycle();
        end
        reg_write(AGE_REG_CONTROL, 32'h0000_0001);
        repeat (10) begin
            tick   = 1'b1;
            freeze = 1'b1;
            run_cycle();
        end
        repeat (10) begin
            tick = 1'b1;
            run_cycle();
        end
        reg_read(AGE_REG_TIMER);

        repeat (RAND_CYCLES) random_cycle();

        // Clear held, then released
        reg_write(AGE_REG_CONTROL, 32'h0000_0005);
        repeat (3) begin
            tick = 1'b1;
            run_cycle();
        end
        reg_read(AGE_REG_STATUS);
        reg_write(AGE_REG_CONTROL, 32'h0000_0001);
        reg_read(AGE_REG_TIMER);

        // Back-to-back touches, then checks every cycle
        reg_write(AGE_REG_TIMEOUT, 32'h0000_0003);
        for (int i = 0; i < `AGE_ENTRIES; i++) begin
            r    = rand16();
            tick = r[15];
            op   = AGE_OP_TOUCH;
            idx  = i[`AGE_IDX_WID-1:0];
            run_cycle();
        end
        for (int i = 0; i < `AGE_ENTRIES; i++) begin
            r    = rand16();
            tick = r[15];
            op   = AGE_OP_CHECK;
            idx  = i[`AGE_IDX_WID-1:0];
            run_cycle();
        end

        reg_write(AGE_REG_TIMEOUT, 32'h0000_012c);
        repeat (WRAP_CYCLES) wrap_cycle();
        // Drain the pipeline
        repeat (4) run_cycle();

        assert (boundary_hits > 0 && expired_hits > 0 && fresh_hits > 0) else begin
            other_errors++;
            $display("stimulus never produced boundary, expired and fresh results together");
        end
        assert (wrap_hits > 0) else begin
            other_errors++;
            $display("no check was made across a timer wrap");
        end

        $display("errors: result %0d, register %0d, other %0d",
                 result_errors, reg_errors, other_errors);
        if (result_errors + reg_errors + other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : entry_ageing_tb

`default_nettype wire

// File: bench/entry_ageing_properties.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module entry_ageing_properties (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      freeze,
    input ageing_pkg::age_op_e       op,
    input logic                      result_valid,
    // Internal nets of the top level
    input logic [`AGE_TIMER_WID-1:0] timer,
    input logic                      ctl_freeze,
    input logic                      ctl_clear
);

    import ageing_pkg::*;

    // ------------------------------------------------
    // Pipeline
    // ------------------------------------------------
    // Nothing leaves the pipeline while in reset
    result_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else $error("result_valid high while rst_n is low");

    // Check at edge N gives a result after edge N+1
    result_follows_check: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(op == AGE_OP_CHECK, 2))
        else $error("result_valid does not match a check two edges earlier");

    // ------------------------------------------------
    // Timer
    // ------------------------------------------------
    // Either freeze source holds the count, clear aside
    timer_held_when_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        (freeze || ctl_freeze) && !ctl_clear |=> $stable(timer))
        else $error("timer moved while frozen");

endmodule : entry_ageing_properties

bind entry_ageing entry_ageing_properties u_entry_ageing_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .freeze       (freeze),
    .op           (op),
    .result_valid (result_valid),
    .timer        (timer),
    .ctl_freeze   (ctl_freeze),
    .ctl_clear    (ctl_clear)
);

`default_nettype wire

// File: logic/entry_ageing.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module entry_ageing (
    input  logic                     clk,
    input  logic                     rst_n,
    // Timer controls
    input  logic                     tick,
    input  logic                     freeze,
    // Operation
    input  ageing_pkg::age_op_e      op,
    input  logic [`AGE_IDX_WID-1:0]  idx,
    // Register port
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  ageing_pkg::age_reg_e     reg_addr,
    input  logic [`AGE_DATA_WID-1:0] reg_wdata,
    output logic [`AGE_DATA_WID-1:0] reg_rdata,
    // Check result
    output logic                     result_valid,
    output logic [`AGE_IDX_WID-1:0]  result_idx,
    output logic                     result_expired
);

    // ------------------------------------------------
    // Internal wiring
    // ------------------------------------------------
    logic                      ctl_enable;
    logic                      ctl_freeze;
    logic                      ctl_clear;
    logic [`AGE_TIMER_WID-1:0] timeout;
    logic [`AGE_TIMER_WID-1:0] timer;

    // Stage one to stage two
    logic                      rd_valid;
    logic [`AGE_IDX_WID-1:0]   rd_idx;
    logic [`AGE_TIMER_WID-1:0] rd_stamp;

    // Configuration and status
    ageing_ctrl_regs u_ageing_ctrl_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .timer      (timer),
        .ctl_enable (ctl_enable),
        .ctl_freeze (ctl_freeze),
        .ctl_clear  (ctl_clear),
        .timeout    (timeout)
    );

    // Free-running time base
    ageing_timer u_ageing_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .freeze     (freeze),
        .ctl_enable (ctl_enable),
        .ctl_freeze (ctl_freeze),
        .ctl_clear  (ctl_clear),
        .timer      (timer)
    );

    // Stage one
    ageing_table u_ageing_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .idx      (idx),
        .timer    (timer),
        .rd_valid (rd_valid),
        .rd_idx   (rd_idx),
        .rd_stamp (rd_stamp)
    );

    // Stage two
    timer_expiry u_timer_expiry (
        .clk            (clk),
        .rst_n          (rst_n),
        .timer          (timer),
        .timeout        (timeout),
        .rd_valid       (rd_valid),
        .rd_idx         (rd_idx),
        .rd_stamp       (rd_stamp),
        .result_valid   (result_valid),
        .result_idx     (result_idx),
        .result_expired (result_expired)
    );

endmodule : entry_ageing

`default_nettype wire

// File: logic/timer_expiry.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module timer_expiry (
    input  logic                      clk,
    input  logic                      rst_n,
    // Time and configuration
    input  logic [`AGE_TIMER_WID-1:0] timer,
    input  logic [`AGE_TIMER_WID-1:0] timeout,
    // Stage one input
    input  logic                      rd_valid,
    input  logic [`AGE_IDX_WID-1:0]   rd_idx,
    input  logic [`AGE_TIMER_WID-1:0] rd_stamp,
    // Check result
    output logic                      result_valid,
    output logic [`AGE_IDX_WID-1:0]   result_idx,
    output logic                      result_expired
);

    // ------------------------------------------------
    // Threshold
    // ------------------------------------------------
    logic        [`AGE_TIMER_WID-1:0] timeout_thresh;
    logic signed [`AGE_TIMER_WID-1:0] time_delta;
    logic                             expired_nxt;

    // Sampled every edge, aligned with the stamp read
    always_ff @(posedge clk) begin
        timeout_thresh <= timer - timeout;
    end

    // ------------------------------------------------
    // Compare
    // ------------------------------------------------
    // Signed so the timer may wrap
    assign time_delta  = rd_stamp - timeout_thresh;
    assign expired_nxt = (time_delta <= 0);

    // ------------------------------------------------
    // Stage two
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            result_idx     <= rd_idx;
            result_expired <= expired_nxt;
        end
    end

endmodule : timer_expiry

`default_nettype wire

// File: logic/ageing_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module ageing_table (
    input  logic                      clk,
    input  logic                      rst_n,
    // Operation in
    input  ageing_pkg::age_op_e       op,
    input  logic [`AGE_IDX_WID-1:0]   idx,
    // Current time for touches
    input  logic [`AGE_TIMER_WID-1:0] timer,
    // Stage one output
    output logic                      rd_valid,
    output logic [`AGE_IDX_WID-1:0]   rd_idx,
    output logic [`AGE_TIMER_WID-1:0] rd_stamp
);

    import ageing_pkg::*;

    // ------------------------------------------------
    // Stamp storage
    // ------------------------------------------------
    logic [`AGE_TIMER_WID-1:0] stamps [`AGE_ENTRIES];

    logic is_touch;
    logic is_check;

    // Opcode decode
    assign is_touch = (op == AGE_OP_TOUCH);
    assign is_check = (op == AGE_OP_CHECK);

    // All entries start at time zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AGE_ENTRIES; i++) begin
                stamps[i] <= '0;
            end
        end else if (is_touch) begin
            // Timer value before this edge
            stamps[idx] <= timer;
        end
    end

    // ------------------------------------------------
    // Check read, stage one
    // ------------------------------------------------
    // Valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= is_check;
        end
    end

    // Stamp and index captured with the check
    // A touch one cycle earlier is already in the array
    always_ff @(posedge clk) begin
        if (is_check) begin
            rd_idx   <= idx;
            rd_stamp <= stamps[idx];
        end
    end

endmodule : ageing_table

`default_nettype wire

// File: logic/ageing_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module ageing_ctrl_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    // Register port
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  ageing_pkg::age_reg_e      reg_addr,
    input  logic [`AGE_DATA_WID-1:0]  reg_wdata,
    output logic [`AGE_DATA_WID-1:0]  reg_rdata,
    // Timer readback
    input  logic [`AGE_TIMER_WID-1:0] timer,
    // Control outputs
    output logic                      ctl_enable,
    output logic                      ctl_freeze,
    output logic                      ctl_clear,
    output logic [`AGE_TIMER_WID-1:0] timeout
);

    import ageing_pkg::*;

    logic [`AGE_DATA_WID-1:0] control_rd;
    logic [`AGE_DATA_WID-1:0] status_rd;
    logic [`AGE_DATA_WID-1:0] rd_mux;

    // ------------------------------------------------
    // Writable registers
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl_enable <= 1'b0;
            ctl_freeze <= 1'b0;
            ctl_clear  <= 1'b0;
            timeout    <= '0;
        end else if (reg_wr) begin
            // STATUS and TIMER are read only
            case (reg_addr)
                AGE_REG_CONTROL: begin
                    ctl_enable <= reg_wdata[CTRL_ENABLE_BIT];
                    ctl_freeze <= reg_wdata[CTRL_FREEZE_BIT];
                    ctl_clear  <= reg_wdata[CTRL_CLEAR_BIT];
                end
                AGE_REG_TIMEOUT: timeout <= reg_wdata[`AGE_TIMER_WID-1:0];
                default: ;
            endcase
        end
    end

    // ------------------------------------------------
    // Read data
    // ------------------------------------------------
    always_comb begin
        control_rd                  = '0;
        control_rd[CTRL_ENABLE_BIT] = ctl_enable;
        control_rd[CTRL_FREEZE_BIT] = ctl_freeze;
        control_rd[CTRL_CLEAR_BIT]  = ctl_clear;
    end

    // Live status, enable reported off while clearing
    always_comb begin
        status_rd                  = '0;
        status_rd[STAT_CLEAR_BIT]  = ctl_clear;
        status_rd[STAT_ENABLE_BIT] = ctl_enable & ~ctl_clear;
        status_rd[STAT_READY_BIT]  = ~ctl_clear;
    end

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            AGE_REG_CONTROL: rd_mux = control_rd;
            AGE_REG_TIMEOUT: rd_mux = {{(`AGE_DATA_WID-`AGE_TIMER_WID){1'b0}}, timeout};
            AGE_REG_STATUS:  rd_mux = status_rd;
            AGE_REG_TIMER:   rd_mux = {{(`AGE_DATA_WID-`AGE_TIMER_WID){1'b0}}, timer};
            default:         rd_mux = '0;
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule : ageing_ctrl_regs

`default_nettype wire

// File: logic/ageing_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "ageing_settings.svh"

module ageing_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    // External controls
    input  logic                      tick,
    input  logic                      freeze,
    // From control register
    input  logic                      ctl_enable,
    input  logic                      ctl_freeze,
    input  logic                      ctl_clear,
    // Current time
    output logic [`AGE_TIMER_WID-1:0] timer
);

    // ------------------------------------------------
    // Count qualification
    // ------------------------------------------------
    logic freeze_any;
    logic count_en;

    // Either freeze source holds the count
    assign freeze_any = freeze | ctl_freeze;

    // Advance only on an enabled, unfrozen tick
    assign count_en = tick & ctl_enable & ~freeze_any;

    // ------------------------------------------------
    // Counter
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
        end else if (ctl_clear) begin
            // Clear wins over counting
            timer <= '0;
        end else if (count_en) begin
            // Wraps modulo 2^16
            timer <= timer + 1'b1;
        end
    end

endmodule : ageing_timer

`default_nettype wire

// File: logic/ageing_pkg.sv
`default_nettype none

package ageing_pkg;

    // ------------------------------------------------
    // Operation opcodes
    // ------------------------------------------------
    typedef enum logic [1:0] {
        AGE_OP_NONE  = 2'd0,
        AGE_OP_TOUCH = 2'd1,
        AGE_OP_CHECK = 2'd2
    } age_op_e;

    // ------------------------------------------------
    // Register map
    // ------------------------------------------------
    typedef enum logic [1:0] {
        AGE_REG_CONTROL = 2'd0,
        AGE_REG_TIMEOUT = 2'd1,
        AGE_REG_STATUS  = 2'd2,
        AGE_REG_TIMER   = 2'd3
    } age_reg_e;

    // Control register fields
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FREEZE_BIT = 1;
    localparam int CTRL_CLEAR_BIT  = 2;

    // Status register fields
    localparam int STAT_CLEAR_BIT  = 0;
    localparam int STAT_ENABLE_BIT = 1;
    localparam int STAT_READY_BIT  = 2;

endpackage : ageing_pkg

`default_nettype wire

// File: include/ageing_settings.svh
`ifndef AGEING_SETTINGS_SVH
`define AGEING_SETTINGS_SVH

// Timer and stamp width
`define AGE_TIMER_WID 16

// Table depth
`define AGE_ENTRIES 16

// Entry index width, log2 of depth
`define AGE_IDX_WID 4

// Register port data width
`define AGE_DATA_WID 32

`endif
